//--- branch_predictor.f
logic/bp_cfg_pkg.sv
logic/rv_instr_pkg.sv
logic/instr_predecode.sv
logic/btb_predictor.sv
logic/return_stack.sv
logic/branch_predictor_top.sv
tb/tb_clock_gen.sv
tb/tb_branch_predictor.sv

//--- logic/bp_cfg_pkg.sv
// Branch predictor configuration
// Sizes and widths that the BTB, the return address stack and the
// top level share: program counter width, BTB geometry, direction
// counter encoding and return stack depth.

package bp_cfg_pkg;

    // program counter
    localparam int ADDR_W = 32;
    // fixed instruction size, no compressed instructions
    localparam int INSTR_BYTES = 4;
    // low PC bits that are always zero for 4-byte instructions
    localparam int BYTE_OFS_W = 2;

    // direct-mapped BTB geometry
    localparam int BTB_ENTRIES = 16;
    localparam int BTB_IDX_W = $clog2(BTB_ENTRIES);
    // tag is every PC bit above the index
    localparam int BTB_TAG_W = ADDR_W - BTB_IDX_W - BYTE_OFS_W;

    // 2-bit saturating direction counter
    localparam int CTR_W = 2;
    // counter values at or above this predict taken
    localparam int CTR_TAKEN_MIN = 2;

    // return address stack
    localparam int RAS_DEPTH = 4;
    localparam int RAS_PTR_W = $clog2(RAS_DEPTH);

endpackage

//--- logic/branch_predictor_top.sv
// Next fetch address predictor
// Predecodes the fetched instruction, drives the return address stack
// from calls and returns, and picks the final prediction: stack top
// for a return when the stack holds an entry, else the BTB when it
// hits with a taken counter, else fall through to the next word.
// The execute stage trains the BTB with branches and jumps only.

`timescale 1ns/100ps

module branch_predictor_top (
    input  logic                          CLK,
    input  logic                          rst,
    input  logic                          fetch_valid,
    input  logic [bp_cfg_pkg::ADDR_W-1:0] current_pc,
    input  logic [rv_instr_pkg::INSTR_W-1:0] instr,
    output logic                          predict_taken,
    output logic [bp_cfg_pkg::ADDR_W-1:0] target_addr,
    input  logic                          update_predictor,
    input  logic [bp_cfg_pkg::ADDR_W-1:0] pc_to_update,
    input  logic                          branch_result,
    input  logic [bp_cfg_pkg::ADDR_W-1:0] update_addr,
    input  logic                          is_branch,
    input  logic                          is_jump
);
    import bp_cfg_pkg::*;
    import rv_instr_pkg::*;

    instr_kind_t       instr_kind;
    logic [ADDR_W-1:0] fall_through;

    // BTB
    logic              btb_update;
    logic              btb_hit;
    logic              btb_taken;
    logic [ADDR_W-1:0] btb_target;

    // return stack
    logic              ras_push;
    logic              ras_pop;
    logic [ADDR_W-1:0] ras_top;
    logic              ras_empty;

    assign fall_through = current_pc + ADDR_W'(INSTR_BYTES);

    // only resolved control transfers train the BTB
    assign btb_update = update_predictor && (is_branch || is_jump);

    // stack moves at the edge that samples the fetch
    // return address is the word after the call
    assign ras_push = fetch_valid && (instr_kind == kind_call);
    assign ras_pop = fetch_valid && (instr_kind == kind_return);

    instr_predecode predecode_inst (
        .instr      (instr),
        .instr_kind (instr_kind)
    );

    btb_predictor btb_inst (
        .CLK              (CLK),
        .rst              (rst),
        .lookup_pc        (current_pc),
        .hit              (btb_hit),
        .btb_taken        (btb_taken),
        .btb_target       (btb_target),
        .update_predictor (btb_update),
        .pc_to_update     (pc_to_update),
        .branch_result    (branch_result),
        .update_addr      (update_addr),
        .is_jump          (is_jump)
    );

    return_stack ras_inst (
        .CLK       (CLK),
        .rst       (rst),
        .push      (ras_push),
        .push_addr (fall_through),
        .pop       (ras_pop),
        .top_addr  (ras_top),
        .empty     (ras_empty)
    );

    // final selection, stack first, then BTB, then fall through
    always_comb begin
        if ((instr_kind == kind_return) && !ras_empty) begin
            predict_taken = 1'b1;
            target_addr = ras_top;
        end else if (btb_hit && btb_taken) begin
            predict_taken = 1'b1;
            target_addr = btb_target;
        end else begin
            predict_taken = 1'b0;
            target_addr = fall_through;
        end
    end

endmodule

//--- logic/btb_predictor.sv
// Branch target buffer with 2-bit direction counters
// Direct-mapped and tagged. Each row keeps a valid bit, a tag, the
// last taken target and a saturating counter. Lookup is combinational
// from the fetch PC; training writes one row at the clock edge that
// samples the update strobe.

`timescale 1ns/100ps

module btb_predictor (
    input  logic                          CLK,
    input  logic                          rst,
    input  logic [bp_cfg_pkg::ADDR_W-1:0] lookup_pc,
    output logic                          hit,
    output logic                          btb_taken,
    output logic [bp_cfg_pkg::ADDR_W-1:0] btb_target,
    input  logic                          update_predictor,
    input  logic [bp_cfg_pkg::ADDR_W-1:0] pc_to_update,
    input  logic                          branch_result,
    input  logic [bp_cfg_pkg::ADDR_W-1:0] update_addr,
    input  logic                          is_jump
);
    import bp_cfg_pkg::*;

    // row storage
    logic [BTB_ENTRIES-1:0] valid_q;
    logic [BTB_TAG_W-1:0]   tag_q    [BTB_ENTRIES];
    logic [ADDR_W-1:0]      target_q [BTB_ENTRIES];
    logic [CTR_W-1:0]       ctr_q    [BTB_ENTRIES];

    // lookup side
    logic [BTB_IDX_W-1:0] rd_idx;
    logic [BTB_TAG_W-1:0] rd_tag;

    // training side
    logic [BTB_IDX_W-1:0] wr_idx;
    logic [BTB_TAG_W-1:0] wr_tag;
    logic                 wr_hit;
    logic                 wr_up;
    logic [CTR_W-1:0]     wr_ctr;
    logic [CTR_W-1:0]     ctr_next;

    // index sits just above the byte offset, tag takes the rest
    assign rd_idx = lookup_pc[BYTE_OFS_W +: BTB_IDX_W];
    assign rd_tag = lookup_pc[BYTE_OFS_W + BTB_IDX_W +: BTB_TAG_W];

    assign hit = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    // counter decision only, the top qualifies it with hit
    assign btb_taken = (ctr_q[rd_idx] >= CTR_W'(CTR_TAKEN_MIN));
    assign btb_target = target_q[rd_idx];

    assign wr_idx = pc_to_update[BYTE_OFS_W +: BTB_IDX_W];
    assign wr_tag = pc_to_update[BYTE_OFS_W + BTB_IDX_W +: BTB_TAG_W];
    assign wr_hit = valid_q[wr_idx] && (tag_q[wr_idx] == wr_tag);
    assign wr_ctr = ctr_q[wr_idx];

    // jumps always train toward taken
    assign wr_up = branch_result || is_jump;

    // next counter value for the row being trained
    always_comb begin
        if (!wr_hit) begin
            // new row starts weakly taken or weakly not taken
            ctr_next = wr_up ? CTR_W'(CTR_TAKEN_MIN) : CTR_W'(CTR_TAKEN_MIN - 1);
        end else if (wr_up) begin
            // saturate at all ones
            ctr_next = (&wr_ctr) ? wr_ctr : wr_ctr + 1'b1;
        end else begin
            // saturate at zero
            ctr_next = (wr_ctr == '0) ? wr_ctr : wr_ctr - 1'b1;
        end
    end

    // valid bits are the only state cleared by reset
    always_ff @(posedge CLK) begin
        if (rst) begin
            valid_q <= '0;
        end else if (update_predictor) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // tag, target and counter of the trained row
    always_ff @(posedge CLK) begin
        if (update_predictor) begin
            tag_q[wr_idx] <= wr_tag;
            ctr_q[wr_idx] <= ctr_next;
            // a replaced row always takes the new target
            // a matching row only moves it on a taken outcome
            if (!wr_hit || branch_result) begin
                target_q[wr_idx] <= update_addr;
            end
        end
    end

endmodule

//--- logic/instr_predecode.sv
// Fetch predecoder
// Looks at the opcode, rd and rs1 of a fetched instruction and
// classifies it as a conditional branch, a plain jal, a call, a
// return or anything else. Purely combinational.

`timescale 1ns/100ps

module instr_predecode (
    input  logic [rv_instr_pkg::INSTR_W-1:0] instr,
    output rv_instr_pkg::instr_kind_t        instr_kind
);
    import rv_instr_pkg::*;

    logic [OPC_W-1:0]      opcode;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic                  rd_link;
    logic                  rs1_link;
    logic                  rd_zero;

    // standard R/I field positions
    assign opcode = instr[OPC_W-1:0];
    assign rd = instr[11:7];
    assign rs1 = instr[19:15];

    // x1 and x5 both count as link registers
    assign rd_link = (rd == REG_RA) || (rd == REG_T0);
    assign rs1_link = (rs1 == REG_RA) || (rs1 == REG_T0);
    assign rd_zero = (rd == '0);

    always_comb begin
        instr_kind = kind_other;
        case (opcode)
            OPC_BRANCH: begin
                instr_kind = kind_branch;
            end
            OPC_JAL: begin
                // jal that links is a call, else a plain jump
                instr_kind = rd_link ? kind_call : kind_jal;
            end
            OPC_JALR: begin
                // link write wins over the return check
                if (rd_link) begin
                    instr_kind = kind_call;
                end else if (rs1_link && rd_zero) begin
                    instr_kind = kind_return;
                end
                // other indirect jumps stay kind_other
            end
            default: begin
                instr_kind = kind_other;
            end
        endcase
    end

endmodule

//--- logic/return_stack.sv
// Return address stack
// Four-entry circular buffer of return addresses. A push past the
// depth overwrites the oldest entry, a pop on an empty stack is
// ignored, and a push together with a pop replaces the top entry.
// The top entry and the empty flag are read combinationally.

`timescale 1ns/100ps

module return_stack (
    input  logic                          CLK,
    input  logic                          rst,
    input  logic                          push,
    input  logic [bp_cfg_pkg::ADDR_W-1:0] push_addr,
    input  logic                          pop,
    output logic [bp_cfg_pkg::ADDR_W-1:0] top_addr,
    output logic                          empty
);
    import bp_cfg_pkg::*;

    logic [ADDR_W-1:0]    entry_q [RAS_DEPTH];
    // points at the current top entry
    logic [RAS_PTR_W-1:0] ptr_q;
    logic [RAS_PTR_W-1:0] ptr_inc;
    // number of live entries, saturates at RAS_DEPTH
    logic [RAS_PTR_W:0]   count_q;
    logic                 full;
    logic                 do_pop;

    assign empty = (count_q == '0);
    assign full = (count_q == (RAS_PTR_W + 1)'(RAS_DEPTH));
    assign top_addr = entry_q[ptr_q];

    // wraps naturally for a power of two depth
    assign ptr_inc = ptr_q + 1'b1;

    assign do_pop = pop && !empty;

    always_ff @(posedge CLK) begin
        if (rst) begin
            ptr_q <= '0;
            count_q <= '0;
        end else if (push && do_pop) begin
            // top replaced in place, depth unchanged
            ptr_q <= ptr_q;
        end else if (push) begin
            ptr_q <= ptr_inc;
            // when full the oldest entry is lost
            if (!full) begin
                count_q <= count_q + 1'b1;
            end
        end else if (do_pop) begin
            ptr_q <= ptr_q - 1'b1;
            count_q <= count_q - 1'b1;
        end
    end

    // address storage
    always_ff @(posedge CLK) begin
        if (push && do_pop) begin
            entry_q[ptr_q] <= push_addr;
        end else if (push) begin
            entry_q[ptr_inc] <= push_addr;
        end
    end

endmodule

//--- logic/rv_instr_pkg.sv
// RV32 instruction encodings for the predictor
// Field widths, the major opcodes of control transfer instructions,
// the link registers used by the calling convention and the
// instruction kind reported by the predecoder.

package rv_instr_pkg;

    // base instruction word, RV32C is not supported
    localparam int INSTR_W = 32;
    localparam int OPC_W = 7;
    localparam int REG_ADDR_W = 5;

    // major opcodes, bits [6:0]
    localparam logic [OPC_W-1:0] OPC_BRANCH = 7'b1100011;
    localparam logic [OPC_W-1:0] OPC_JAL = 7'b1101111;
    localparam logic [OPC_W-1:0] OPC_JALR = 7'b1100111;

    // link registers, ra and the alternate link t0
    localparam logic [REG_ADDR_W-1:0] REG_RA = 5'd1;
    localparam logic [REG_ADDR_W-1:0] REG_T0 = 5'd5;

    // what the fetch side needs to know about an instruction
    // kind_call covers jal and jalr that write a link register
    // kind_return is a jalr through a link register with rd = x0
    typedef enum logic [2:0] {
        kind_other  = 3'd0,
        kind_branch = 3'd1,
        kind_jal    = 3'd2,
        kind_call   = 3'd3,
        kind_return = 3'd4
    } instr_kind_t;

endpackage

//--- run_sim.sh
#!/bin/sh
# Builds the branch predictor testbench with Verilator, runs it and
# checks the simulation log for the failure message.
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG" build.log
verilator --binary --timing -Wno-fatal --top-module tb_branch_predictor \
    -f branch_predictor.f -o sim_branch_predictor > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/sim_branch_predictor > "$LOG" 2>&1 \
    || echo "simulation returned a nonzero status" >> "$LOG"
cat "$LOG"
grep -q "Regression failed" "$LOG" && exit 1
grep -q "Regression passed" "$LOG" || exit 1
exit 0

//--- tb/tb_branch_predictor.sv
// Branch predictor testbench
// Drives fetches and training updates into the predictor on the
// falling clock edge and checks the combinational prediction before
// every rising edge against a behavioral model of the BTB, the
// return address stack and the selection rule. Directed tests come
// first, then a long seeded random mix.

`timescale 1ns/100ps

module tb_branch_predictor;
    import bp_cfg_pkg::*;
    import rv_instr_pkg::*;

    localparam int RESET_TIMEOUT = 20;
    localparam int RANDOM_CYCLES = 3000;
    localparam int CTR_MAX = (1 << CTR_W) - 1;

    logic                CLK;
    logic                rst;
    logic                fetch_valid;
    logic [ADDR_W-1:0]   current_pc;
    logic [INSTR_W-1:0]  instr;
    logic                predict_taken;
    logic [ADDR_W-1:0]   target_addr;
    logic                update_predictor;
    logic [ADDR_W-1:0]   pc_to_update;
    logic                branch_result;
    logic [ADDR_W-1:0]   update_addr;
    logic                is_branch;
    logic                is_jump;

    // kind the current instruction word was built as
    instr_kind_t         cur_kind;
    string               test_name;
    logic [31:0]         rng_state;

    // model of the BTB rows
    logic                m_valid  [BTB_ENTRIES];
    logic [BTB_TAG_W-1:0] m_tag   [BTB_ENTRIES];
    logic [ADDR_W-1:0]   m_target [BTB_ENTRIES];
    int                  m_ctr    [BTB_ENTRIES];
    // model of the return stack, newest entry at the back
    logic [ADDR_W-1:0]   m_stack [$];

    tb_clock_gen clock_gen_inst (
        .CLK (CLK),
        .rst (rst)
    );

    branch_predictor_top branch_predictor_top_inst (
        .CLK              (CLK),
        .rst              (rst),
        .fetch_valid      (fetch_valid),
        .current_pc       (current_pc),
        .instr            (instr),
        .predict_taken    (predict_taken),
        .target_addr      (target_addr),
        .update_predictor (update_predictor),
        .pc_to_update     (pc_to_update),
        .branch_result    (branch_result),
        .update_addr      (update_addr),
        .is_branch        (is_branch),
        .is_jump          (is_jump)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // 16 PCs over four BTB rows with four tags each, so rows alias
    function automatic logic [ADDR_W-1:0] pool_pc(input logic [31:0] r);
        return 32'h0000_2000 | {24'd0, r[4:3], 2'b00, r[1:0], 2'b00};
    endfunction

    // weighted so returns and calls show up often
    function automatic instr_kind_t random_kind(input logic [31:0] r);
        case (r[2:0])
            3'd0, 3'd1: return kind_branch;
            3'd2: return kind_jal;
            3'd3: return kind_call;
            3'd4, 3'd5: return kind_return;
            default: return kind_other;
        endcase
    endfunction

    // encodes a word of the requested kind with random filler fields
    function automatic logic [INSTR_W-1:0] build_instr(input instr_kind_t kind,
                                                       input logic [31:0] r);
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] link;
        link = r[0] ? REG_T0 : REG_RA;
        rd = r[11:7];
        case (kind)
            kind_branch: return {r[31:7], OPC_BRANCH};
            kind_jal: begin
                // plain jump must not write a link register
                if (rd == REG_RA || rd == REG_T0) begin
                    rd = '0;
                end
                return {r[31:12], rd, OPC_JAL};
            end
            kind_call: begin
                if (r[1]) begin
                    return {r[31:12], link, OPC_JAL};
                end
                return {r[31:20], r[19:15], 3'b000, link, OPC_JALR};
            end
            kind_return: return {r[31:20], link, 3'b000, 5'd0, OPC_JALR};
            default: begin
                // indirect jump writing x6, or an OP-IMM word
                if (r[2]) begin
                    return {r[31:15], 3'b000, 5'd6, OPC_JALR};
                end
                return {r[31:7], 7'b0010011};
            end
        endcase
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_taken(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[FAIL] %s predict_taken expected %0b actual %0b", name, expected, actual);
            $display("Regression failed");
            $fatal(1, "prediction direction mismatch");
        end
    endtask

    task automatic check_target(input string name, input logic [ADDR_W-1:0] expected,
                                input logic [ADDR_W-1:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s target_addr expected %08h actual %08h", name, expected, actual);
            $display("Regression failed");
            $fatal(1, "prediction target mismatch");
        end
    endtask

    task automatic drive_fetch(input logic valid, input logic [ADDR_W-1:0] pc,
                               input instr_kind_t kind);
        fetch_valid = valid;
        current_pc = pc;
        instr = build_instr(kind, rand_word());
        cur_kind = kind;
    endtask

    task automatic drive_update(input logic en, input logic [ADDR_W-1:0] pc, input logic taken,
                                input logic [ADDR_W-1:0] addr, input logic br,
                                input logic jmp);
        update_predictor = en;
        pc_to_update = pc;
        branch_result = taken;
        update_addr = addr;
        is_branch = br;
        is_jump = jmp;
    endtask

    task automatic update_off();
        drive_update(1'b0, '0, 1'b0, '0, 1'b0, 1'b0);
    endtask

    // expected outputs from the model state before the coming edge
    task automatic model_predict(output logic taken, output logic [ADDR_W-1:0] target);
        int idx;
        logic [BTB_TAG_W-1:0] tag;
        idx = int'(current_pc[BYTE_OFS_W +: BTB_IDX_W]);
        tag = current_pc[ADDR_W-1 -: BTB_TAG_W];
        if (cur_kind == kind_return && m_stack.size() > 0) begin
            taken = 1'b1;
            target = m_stack[m_stack.size() - 1];
        end else if (m_valid[idx] && m_tag[idx] == tag && m_ctr[idx] >= CTR_TAKEN_MIN) begin
            taken = 1'b1;
            target = m_target[idx];
        end else begin
            taken = 1'b0;
            target = current_pc + 32'd4;
        end
    endtask

    // applies the update and the stack move of this cycle
    task automatic model_advance();
        int idx;
        logic [BTB_TAG_W-1:0] tag;
        logic up;
        logic hit;
        if (update_predictor && (is_branch || is_jump)) begin
            idx = int'(pc_to_update[BYTE_OFS_W +: BTB_IDX_W]);
            tag = pc_to_update[ADDR_W-1 -: BTB_TAG_W];
            up = branch_result || is_jump;
            hit = m_valid[idx] && (m_tag[idx] == tag);
            if (!hit) begin
                m_valid[idx] = 1'b1;
                m_tag[idx] = tag;
                m_target[idx] = update_addr;
                m_ctr[idx] = up ? CTR_TAKEN_MIN : CTR_TAKEN_MIN - 1;
            end else begin
                if (up && m_ctr[idx] < CTR_MAX) begin
                    m_ctr[idx]++;
                end else if (!up && m_ctr[idx] > 0) begin
                    m_ctr[idx]--;
                end
                if (branch_result) begin
                    m_target[idx] = update_addr;
                end
            end
        end
        // a call and a return never come from the same word
        if (fetch_valid && cur_kind == kind_call) begin
            m_stack.push_back(current_pc + 32'd4);
            if (m_stack.size() > RAS_DEPTH) begin
                void'(m_stack.pop_front());
            end
        end else if (fetch_valid && cur_kind == kind_return && m_stack.size() > 0) begin
            void'(m_stack.pop_back());
        end
    endtask

    // compare against the model, then move to the next falling edge
    task automatic cycle_check();
        logic exp_taken;
        logic [ADDR_W-1:0] exp_target;
        #2;
        model_predict(exp_taken, exp_target);
        check_taken(test_name, exp_taken, predict_taken);
        check_target(test_name, exp_target, target_addr);
        model_advance();
        @(negedge CLK);
    endtask

    // directed values as well as the model
    task automatic cycle_expect(input logic exp_taken, input logic [ADDR_W-1:0] exp_target);
        #1;
        check_taken(test_name, exp_taken, predict_taken);
        check_target(test_name, exp_target, target_addr);
        cycle_check();
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst !== 1'b0) begin
            @(negedge CLK);
            cycles++;
            if (cycles > RESET_TIMEOUT) begin
                abort_run("reset was not released within the timeout");
            end
        end
    endtask

    initial begin
        int i;
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] u;
        logic [ADDR_W-1:0] pc;
        fetch_valid = 1'b0;
        current_pc = '0;
        instr = '0;
        update_off();
        cur_kind = kind_other;
        test_name = "init";
        rng_state = 32'd97;
        for (i = 0; i < BTB_ENTRIES; i++) begin
            m_valid[i] = 1'b0;
            m_ctr[i] = 0;
        end
        wait_reset_release();

        // empty BTB and stack, everything falls through
        test_name = "reset_state";
        for (i = 0; i < 32; i++) begin
            r = rand_word();
            pc = pool_pc(rand_word());
            drive_fetch(1'b1, pc, (r[0]) ? kind_return : kind_branch);
            cycle_expect(1'b0, pc + 32'd4);
        end

        // two taken updates, then a filtered update, then decay
        test_name = "btb_train_taken";
        for (i = 0; i < 2; i++) begin
            drive_fetch(1'b1, 32'h0000_1010, kind_branch);
            drive_update(1'b1, 32'h0000_1010, 1'b1, 32'h0000_1800, 1'b1, 1'b0);
            cycle_check();
        end
        // taken with a new target, but neither branch nor jump
        drive_fetch(1'b1, 32'h0000_1010, kind_branch);
        drive_update(1'b1, 32'h0000_1010, 1'b1, 32'h0000_1f00, 1'b0, 1'b0);
        cycle_expect(1'b1, 32'h0000_1800);
        update_off();
        cycle_expect(1'b1, 32'h0000_1800);
        test_name = "btb_train_not_taken";
        for (i = 0; i < 4; i++) begin
            drive_fetch(1'b1, 32'h0000_1010, kind_branch);
            drive_update(1'b1, 32'h0000_1010, 1'b0, 32'h0000_0000, 1'b1, 1'b0);
            cycle_check();
        end
        update_off();
        cycle_expect(1'b0, 32'h0000_1014);

        // 0x1010 and 0x1050 share row 4
        test_name = "btb_alias";
        drive_fetch(1'b0, 32'h0000_1010, kind_jal);
        // counter left at zero, two jumps bring it back to taken
        for (i = 0; i < 2; i++) begin
            drive_update(1'b1, 32'h0000_1010, 1'b1, 32'h0000_1a00, 1'b0, 1'b1);
            cycle_check();
        end
        update_off();
        cycle_expect(1'b1, 32'h0000_1a00);
        drive_update(1'b1, 32'h0000_1050, 1'b1, 32'h0000_1c00, 1'b1, 1'b0);
        cycle_check();
        update_off();
        cycle_expect(1'b0, 32'h0000_1014);
        drive_fetch(1'b1, 32'h0000_1050, kind_branch);
        cycle_expect(1'b1, 32'h0000_1c00);

        // nested calls unwind newest first
        test_name = "ras_nested";
        drive_fetch(1'b1, 32'h0000_4000, kind_call);
        cycle_check();
        drive_fetch(1'b1, 32'h0000_4100, kind_call);
        cycle_check();
        drive_fetch(1'b1, 32'h0000_4200, kind_return);
        cycle_expect(1'b1, 32'h0000_4104);
        drive_fetch(1'b1, 32'h0000_4300, kind_return);
        cycle_expect(1'b1, 32'h0000_4004);

        // six calls into four entries, the last returns use the BTB
        test_name = "ras_overflow";
        drive_fetch(1'b0, 32'h0000_5008, kind_return);
        drive_update(1'b1, 32'h0000_5008, 1'b1, 32'h0000_5800, 1'b0, 1'b1);
        cycle_check();
        update_off();
        for (i = 0; i < 6; i++) begin
            drive_fetch(1'b1, 32'h0000_6000 + 32'(i * 16), kind_call);
            cycle_check();
        end
        for (i = 5; i >= 2; i--) begin
            drive_fetch(1'b1, 32'h0000_5008, kind_return);
            cycle_expect(1'b1, 32'h0000_6004 + 32'(i * 16));
        end
        for (i = 0; i < 2; i++) begin
            drive_fetch(1'b1, 32'h0000_5008, kind_return);
            cycle_expect(1'b1, 32'h0000_5800);
        end

        // seeded random fetch and update traffic
        test_name = "random_mix";
        for (i = 0; i < RANDOM_CYCLES; i++) begin
            r = rand_word();
            drive_fetch(r[4:3] != 2'b00, pool_pc(rand_word()), random_kind(r));
            u = rand_word();
            a = rand_word();
            drive_update(u[0], pool_pc(rand_word()), u[1], {a[31:2], 2'b00},
                         u[2], u[3] & u[4]);
            cycle_check();
        end

        $display("Regression passed");
        $finish;
    end

endmodule

//--- tb/tb_clock_gen.sv
// Testbench clock and reset source
// Free running 8 ns clock and a synchronous active high reset that
// is held for the first three rising edges.

`timescale 1ns/100ps

module tb_clock_gen (
    output logic CLK,
    output logic rst
);

    // 4 ns high, 4 ns low
    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // released right at the third rising edge, so the DUT sees it three times
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge CLK);
        rst <= 1'b0;
    end

endmodule
